// File: common/div_params.svh
/*
  global width and operation codes for the divide unit
  DIV_XLEN may be set to 16, 32 or 64
  op codes are the RISC-V M extension funct3 values
*/
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// data path width
`define DIV_XLEN 32

// funct3 encodings of the divide group
`define DIV_OP_DIV  3'b100
`define DIV_OP_DIVU 3'b101
`define DIV_OP_REM  3'b110
`define DIV_OP_REMU 3'b111

`endif

// File: common/div_types_pkg.sv
/*
  data path types of the divide unit
  all widths follow DIV_XLEN from the params header
  the accumulator is one bit wider than a word
*/
package div_types_pkg;

`include "div_params.svh"

    // operand and result word
    typedef logic [`DIV_XLEN-1:0] word_t;

    // partial remainder
    // extra msb holds the shifted-out bit before the compare
    typedef logic [`DIV_XLEN:0] acc_t;

    // index of the current quotient bit
    typedef logic [$clog2(`DIV_XLEN)-1:0] step_t;

endpackage

// File: common/div_ctrl_pkg.sv
/*
  control encodings of the divide unit
  op values match funct3 so decode logic can pass i_op straight in
  only the four divide codes are legal on the op input
*/
package div_ctrl_pkg;

`include "div_params.svh"

    // divide group operations
    typedef enum logic [2:0] {
        OP_DIV  = `DIV_OP_DIV,
        OP_DIVU = `DIV_OP_DIVU,
        OP_REM  = `DIV_OP_REM,
        OP_REMU = `DIV_OP_REMU
    } div_op_t;

    // controller states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_LOAD = 2'd1,
        ST_RUN  = 2'd2,
        ST_DONE = 2'd3
    } div_state_t;

endpackage

// File: divider/div_fsm.sv
/*
  controller of the iterative divider
  one operation in flight, no overlap with a pending result
  done state has a capture cycle, then holds o_out_valid
  until the sink takes the result
*/
module div_fsm (
    input  logic aclk,
    input  logic aresetn,
    input  logic i_valid,
    output logic i_ready_o,
    input  logic i_op_zero,
    input  logic i_last_step,
    input  logic i_out_ready,
    output logic o_load_en,
    output logic o_init,
    output logic o_step_en,
    output logic o_capture_en,
    output logic o_out_valid,
    output logic o_busy
);
    import div_ctrl_pkg::*;

    div_state_t state_q;
    div_state_t state_d;
    // set after the capture cycle of ST_DONE
    logic       valid_q;
    logic       taken;

    assign taken = valid_q && i_out_ready;

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (i_valid) begin
                    state_d = ST_LOAD;
                end
            end
            // zero divisor skips the whole iteration
            ST_LOAD: state_d = i_op_zero ? ST_DONE : ST_RUN;
            ST_RUN: begin
                if (i_last_step) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: begin
                if (taken) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q <= ST_IDLE;
            valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // valid follows the capture in the first done cycle
            if (o_capture_en) begin
                valid_q <= 1'b1;
            end else if (taken) begin
                valid_q <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // strobes and handshake
    //////////////////////////////////////////////////////////////////////
    // prep samples every idle cycle and keeps the value of the accept edge
    assign o_load_en    = (state_q == ST_IDLE);
    assign o_init       = (state_q == ST_LOAD);
    assign o_step_en    = (state_q == ST_RUN);
    assign o_capture_en = (state_q == ST_DONE) && !valid_q;
    assign i_ready_o    = (state_q == ST_IDLE);
    assign o_out_valid  = valid_q;
    assign o_busy       = (state_q != ST_IDLE);

    // a pending result holds the controller in done until taken
    a_valid_held: assert property (
        @(posedge aclk) disable iff (!aresetn)
        o_out_valid && !i_out_ready |=> o_out_valid && (state_q == ST_DONE)
    );

endmodule

// File: divider/div_step_counter.sv
/*
  step counter of the iterative divider
  cleared by init, one count per quotient bit
  last_step is high during the final step cycle
*/
`include "div_params.svh"

module div_step_counter (
    input  logic aclk,
    input  logic aresetn,
    input  logic i_init,
    input  logic i_step_en,
    output logic o_last_step
);
    import div_types_pkg::*;

    localparam step_t LAST = step_t'(`DIV_XLEN - 1);

    step_t count_q;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            count_q <= '0;
        end else if (i_init) begin
            count_q <= '0;
        end else if (i_step_en) begin
            // wrap back to zero after the last bit
            count_q <= (count_q == LAST) ? '0 : count_q + step_t'(1);
        end
    end

    assign o_last_step = (count_q == LAST);

    // controller must stop stepping once the last bit is done
    a_no_extra_step: assert property (
        @(posedge aclk) disable iff (!aresetn)
        i_step_en && o_last_step |=> !i_step_en
    );

endmodule

// File: divider/div_operand_prep.sv
/*
  operand decode and sign handling
  registers magnitudes and flags while i_load_en is high
  so the value from the accept edge is held during the run
  signed overflow needs no special case here
*/
`include "div_params.svh"

module div_operand_prep (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  i_load_en,
    input  div_ctrl_pkg::div_op_t i_op,
    input  div_types_pkg::word_t  i_dividend,
    input  div_types_pkg::word_t  i_divisor,
    output div_types_pkg::word_t  o_dividend_abs,
    output div_types_pkg::word_t  o_divisor_abs,
    output div_types_pkg::word_t  o_dividend_raw,
    output logic                  o_div_zero,
    output logic                  o_q_neg,
    output logic                  o_r_neg,
    output logic                  o_want_rem
);
    import div_types_pkg::*;
    import div_ctrl_pkg::*;

    logic  is_signed;
    logic  want_rem;
    logic  dvd_neg;
    logic  dvs_neg;
    word_t dvd_abs;
    word_t dvs_abs;

    // op decode
    assign is_signed = (i_op == OP_DIV) || (i_op == OP_REM);
    assign want_rem  = (i_op == OP_REM) || (i_op == OP_REMU);

    // only signed ops look at the msb
    assign dvd_neg = is_signed && i_dividend[`DIV_XLEN-1];
    assign dvs_neg = is_signed && i_divisor[`DIV_XLEN-1];

    // two's complement magnitude
    assign dvd_abs = dvd_neg ? (~i_dividend + word_t'(1)) : i_dividend;
    assign dvs_abs = dvs_neg ? (~i_divisor + word_t'(1)) : i_divisor;

    // operand words
    always_ff @(posedge aclk) begin
        if (i_load_en) begin
            o_dividend_abs <= dvd_abs;
            o_divisor_abs  <= dvs_abs;
            // kept for the divide by zero remainder
            o_dividend_raw <= i_dividend;
        end
    end

    // flags
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            o_div_zero <= 1'b0;
            o_q_neg    <= 1'b0;
            o_r_neg    <= 1'b0;
            o_want_rem <= 1'b0;
        end else if (i_load_en) begin
            o_div_zero <= (i_divisor == '0);
            // quotient negative when signs differ
            o_q_neg    <= dvd_neg ^ dvs_neg;
            // remainder follows the dividend
            o_r_neg    <= dvd_neg;
            o_want_rem <= want_rem;
        end
    end

endmodule

// File: divider/div_restoring_core.sv
/*
  restoring shift-subtract divider core
  unsigned magnitudes only, one quotient bit per step
  result is valid after DIV_XLEN steps following init
  divisor must be non-zero while stepping
*/
`include "div_params.svh"

module div_restoring_core (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 i_init,
    input  logic                 i_step_en,
    input  div_types_pkg::word_t i_dividend_abs,
    input  div_types_pkg::word_t i_divisor_abs,
    output div_types_pkg::word_t o_quot,
    output div_types_pkg::word_t o_rem
);
    import div_types_pkg::*;

    acc_t  acc_q;
    // dividend bits shift out the top as quotient bits enter the bottom
    word_t quot_q;
    acc_t  shifted;
    acc_t  divisor_ext;
    acc_t  diff;
    logic  fits;

    //////////////////////////////////////////////////////////////////////
    // one step
    //////////////////////////////////////////////////////////////////////
    // bring down the next dividend bit
    assign shifted     = {acc_q[`DIV_XLEN-1:0], quot_q[`DIV_XLEN-1]};
    assign divisor_ext = {1'b0, i_divisor_abs};
    assign diff        = shifted - divisor_ext;
    // subtract only when the divisor fits
    assign fits        = (shifted >= divisor_ext);

    always_ff @(posedge aclk) begin
        if (i_init) begin
            acc_q  <= '0;
            quot_q <= i_dividend_abs;
        end else if (i_step_en) begin
            if (fits) begin
                acc_q  <= diff;
                quot_q <= {quot_q[`DIV_XLEN-2:0], 1'b1};
            end else begin
                acc_q  <= shifted;
                quot_q <= {quot_q[`DIV_XLEN-2:0], 1'b0};
            end
        end
    end

    // remainder is below the divisor so the top bit is zero
    assign o_quot = quot_q;
    assign o_rem  = acc_q[`DIV_XLEN-1:0];

    // zero divisor is routed around the run state
    a_divisor_nonzero: assert property (
        @(posedge aclk) disable iff (!aresetn)
        i_step_en |-> (i_divisor_abs != '0)
    );

endmodule

// File: divider/div_result_fixup.sv
/*
  sign restore, divide by zero substitution and result select
  output word is captured once per operation on i_capture_en
  and held until the next capture
*/
module div_result_fixup (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 i_capture_en,
    input  div_types_pkg::word_t i_quot,
    input  div_types_pkg::word_t i_rem,
    input  div_types_pkg::word_t i_dividend_raw,
    input  logic                 i_div_zero,
    input  logic                 i_q_neg,
    input  logic                 i_r_neg,
    input  logic                 i_want_rem,
    output div_types_pkg::word_t o_result,
    output logic                 o_div_zero
);
    import div_types_pkg::*;

    word_t quot_signed;
    word_t rem_signed;
    word_t quot_final;
    word_t rem_final;
    word_t result_sel;

    // back to signed
    assign quot_signed = i_q_neg ? (~i_quot + word_t'(1)) : i_quot;
    assign rem_signed  = i_r_neg ? (~i_rem + word_t'(1)) : i_rem;

    // riscv divide by zero results
    assign quot_final = i_div_zero ? '1 : quot_signed;
    assign rem_final  = i_div_zero ? i_dividend_raw : rem_signed;

    assign result_sel = i_want_rem ? rem_final : quot_final;

    // result word
    always_ff @(posedge aclk) begin
        if (i_capture_en) begin
            o_result <= result_sel;
        end
    end

    // zero flag
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            o_div_zero <= 1'b0;
        end else if (i_capture_en) begin
            o_div_zero <= i_div_zero;
        end
    end

endmodule

// File: hdl/div_unit_top.sv
/*
  iterative 32-bit divide unit for the M extension
  valid/ready on both sides, one operation at a time
  non-zero divisor gives o_valid DIV_XLEN+2 edges after accept
  zero divisor gives o_valid 2 edges after accept
*/
module div_unit_top (
    input  logic                  aclk,
    input  logic                  aresetn,
    // request side
    input  logic                  i_valid,
    output logic                  i_ready,
    input  div_ctrl_pkg::div_op_t i_op,
    input  div_types_pkg::word_t  i_dividend,
    input  div_types_pkg::word_t  i_divisor,
    // response side
    output logic                  o_valid,
    input  logic                  o_ready,
    output div_types_pkg::word_t  o_result,
    output logic                  o_div_zero,
    output logic                  o_busy
);
    import div_types_pkg::*;

    // controller strobes
    logic  load_en;
    logic  init;
    logic  step_en;
    logic  capture_en;
    logic  last_step;
    // prep outputs
    word_t dividend_abs;
    word_t divisor_abs;
    word_t dividend_raw;
    logic  div_zero;
    logic  q_neg;
    logic  r_neg;
    logic  want_rem;
    // core outputs
    word_t quot;
    word_t rem;

    div_fsm i_div_fsm (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_valid      (i_valid),
        .i_ready_o    (i_ready),
        .i_op_zero    (div_zero),
        .i_last_step  (last_step),
        .i_out_ready  (o_ready),
        .o_load_en    (load_en),
        .o_init       (init),
        .o_step_en    (step_en),
        .o_capture_en (capture_en),
        .o_out_valid  (o_valid),
        .o_busy       (o_busy)
    );

    div_step_counter i_div_step_counter (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_init      (init),
        .i_step_en   (step_en),
        .o_last_step (last_step)
    );

    div_operand_prep i_div_operand_prep (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_load_en      (load_en),
        .i_op           (i_op),
        .i_dividend     (i_dividend),
        .i_divisor      (i_divisor),
        .o_dividend_abs (dividend_abs),
        .o_divisor_abs  (divisor_abs),
        .o_dividend_raw (dividend_raw),
        .o_div_zero     (div_zero),
        .o_q_neg        (q_neg),
        .o_r_neg        (r_neg),
        .o_want_rem     (want_rem)
    );

    div_restoring_core i_div_restoring_core (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_init         (init),
        .i_step_en      (step_en),
        .i_dividend_abs (dividend_abs),
        .i_divisor_abs  (divisor_abs),
        .o_quot         (quot),
        .o_rem          (rem)
    );

    div_result_fixup i_div_result_fixup (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_capture_en   (capture_en),
        .i_quot         (quot),
        .i_rem          (rem),
        .i_dividend_raw (dividend_raw),
        .i_div_zero     (div_zero),
        .i_q_neg        (q_neg),
        .i_r_neg        (r_neg),
        .i_want_rem     (want_rem),
        .o_result       (o_result),
        .o_div_zero     (o_div_zero)
    );

endmodule

// File: testbench/tb_div_checks.svh
/*
  compare and wait helpers for the divide unit testbench
  included inside the testbench module body
  the first mismatch or timeout ends the run
*/
`ifndef TB_DIV_CHECKS_SVH
`define TB_DIV_CHECKS_SVH

// verdict for any failing end of the run
task automatic abort_run();
    $display("Checks failed");
    $fatal(1);
endtask

//////////////////////////////////////////////////////////////////////
// typed compares
//////////////////////////////////////////////////////////////////////
task automatic check_word(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
        $display("[FAIL] time %0t: %s expected %h, actual %h", $time, name, expected, actual);
        abort_run();
    end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
        $display("[FAIL] time %0t: %s expected %b, actual %b", $time, name, expected, actual);
        abort_run();
    end
endtask

// edge counts between handshake events
task automatic check_count(input string name, input int actual, input int expected);
    if (actual != expected) begin
        $display("[FAIL] time %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
        abort_run();
    end
endtask

//////////////////////////////////////////////////////////////////////
// bounded waits polled just after the rising edge
//////////////////////////////////////////////////////////////////////
task automatic wait_ready(input int limit);
    int waited;
    waited = 0;
    while (!i_ready) begin
        if (waited >= limit) begin
            $display("timeout: i_ready stayed low for %0d cycles at time %0t", limit, $time);
            abort_run();
        end
        @(posedge aclk);
        #1;
        waited++;
    end
endtask

task automatic wait_drained(input int limit);
    int waited;
    waited = 0;
    while (n_done != n_sent) begin
        if (waited >= limit) begin
            $display("timeout: %0d of %0d results never came back", n_sent - n_done, n_sent);
            abort_run();
        end
        @(posedge aclk);
        #1;
        waited++;
    end
endtask

`endif

// File: testbench/tb_div_unit.sv
/*
  testbench for the iterative divide unit
  directed and random DIV, DIVU, REM, REMU operations
  outputs are sampled on the falling edge, inputs change 1 unit after rise
  o_ready is stalled at random only in the last phase
*/
`include "div_params.svh"

module tb_div_unit;
    import div_types_pkg::*;
    import div_ctrl_pkg::*;

    localparam int FULL_LAT   = `DIV_XLEN + 2;
    localparam int ZERO_LAT   = 2;
    localparam int WAIT_LIMIT = 2000;

    logic        aclk = 1'b0;
    logic        aresetn;
    logic        i_valid;
    logic        i_ready;
    div_op_t     i_op;
    word_t       i_dividend;
    word_t       i_divisor;
    logic        o_valid;
    logic        o_ready;
    word_t       o_result;
    logic        o_div_zero;
    logic        o_busy;

    // expected results with one entry per accepted operation
    word_t       exp_result_q[$];
    logic        exp_zero_q[$];
    int          exp_lat_q[$];
    int          n_sent = 0;
    int          n_done = 0;
    int          edge_cnt = 0;
    int          accept_edge = 0;
    logic        in_flight = 1'b0;
    logic        valid_seen = 1'b0;
    // last offered result while the sink stalls
    logic        hold_pending = 1'b0;
    word_t       held_result = '0;
    logic        held_zero = 1'b0;
    logic        stall_mode = 1'b0;
    int unsigned seed_val;

    `include "tb_div_checks.svh"

    div_unit_top i_div_unit_top (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_valid    (i_valid),
        .i_ready    (i_ready),
        .i_op       (i_op),
        .i_dividend (i_dividend),
        .i_divisor  (i_divisor),
        .o_valid    (o_valid),
        .o_ready    (o_ready),
        .o_result   (o_result),
        .o_div_zero (o_div_zero),
        .o_busy     (o_busy)
    );

    always #5 aclk = ~aclk;

    always @(posedge aclk) begin
        edge_cnt <= edge_cnt + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    // truncating division where the remainder takes the dividend's sign
    function automatic word_t ref_div(input div_op_t op, input word_t a, input word_t b);
        logic               is_signed;
        logic               a_neg;
        logic               b_neg;
        logic [`DIV_XLEN:0] a_mag;
        logic [`DIV_XLEN:0] b_mag;
        logic [`DIV_XLEN:0] q_mag;
        logic [`DIV_XLEN:0] r_mag;
        word_t              q;
        word_t              r;
        is_signed = (op == OP_DIV) || (op == OP_REM);
        a_neg = is_signed && a[`DIV_XLEN-1];
        b_neg = is_signed && b[`DIV_XLEN-1];
        // one extra bit so the most negative value has a magnitude
        a_mag = a_neg ? -{1'b1, a} : {1'b0, a};
        b_mag = b_neg ? -{1'b1, b} : {1'b0, b};
        if (b == '0) begin
            q = '1;
            r = a;
        end else begin
            q_mag = a_mag / b_mag;
            r_mag = a_mag % b_mag;
            q = q_mag[`DIV_XLEN-1:0];
            r = r_mag[`DIV_XLEN-1:0];
            if (a_neg ^ b_neg) begin
                q = -q;
            end
            if (a_neg) begin
                r = -r;
            end
        end
        return ((op == OP_REM) || (op == OP_REMU)) ? r : q;
    endfunction

    function automatic word_t rand_word();
        logic [63:0] bits;
        bits = {$urandom(), $urandom()};
        return bits[`DIV_XLEN-1:0];
    endfunction

    function automatic div_op_t rand_op();
        div_op_t op;
        case ($urandom % 4)
            0: op = OP_DIV;
            1: op = OP_DIVU;
            2: op = OP_REM;
            default: op = OP_REMU;
        endcase
        return op;
    endfunction

    // holds the request until the accept edge
    task automatic send_op(input div_op_t op, input word_t a, input word_t b);
        i_valid    = 1'b1;
        i_op       = op;
        i_dividend = a;
        i_divisor  = b;
        wait_ready(WAIT_LIMIT);
        @(posedge aclk);
        #1;
        i_valid    = 1'b0;
        // idle bus noise that is never accepted
        i_op       = rand_op();
        i_dividend = rand_word();
        i_divisor  = rand_word();
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare process
    //////////////////////////////////////////////////////////////////////
    // values seen here are the ones the next rising edge samples
    always @(negedge aclk) begin
        if (aresetn) begin
            if (in_flight) begin
                check_bit("o_busy", o_busy, 1'b1);
                check_bit("i_ready", i_ready, 1'b0);
            end else begin
                check_bit("o_busy", o_busy, 1'b0);
                check_bit("i_ready", i_ready, 1'b1);
                check_bit("o_valid", o_valid, 1'b0);
            end
            // stalled result must not move
            if (hold_pending) begin
                check_bit("o_valid", o_valid, 1'b1);
                check_word("o_result", o_result, held_result);
                check_bit("o_div_zero", o_div_zero, held_zero);
            end
            if (o_valid && !valid_seen) begin
                valid_seen = 1'b1;
                check_count("o_valid edges after accept", edge_cnt - accept_edge, exp_lat_q[0]);
            end
            hold_pending = o_valid && !o_ready;
            held_result  = o_result;
            held_zero    = o_div_zero;
            // output transfer on the coming edge
            if (o_valid && o_ready) begin
                check_word("o_result", o_result, exp_result_q.pop_front());
                check_bit("o_div_zero", o_div_zero, exp_zero_q.pop_front());
                exp_lat_q.delete(0);
                n_done++;
                in_flight  = 1'b0;
                valid_seen = 1'b0;
            end
            // input transfer on the coming edge
            if (i_valid && i_ready) begin
                exp_result_q.push_back(ref_div(i_op, i_dividend, i_divisor));
                exp_zero_q.push_back(i_divisor == '0);
                exp_lat_q.push_back((i_divisor == '0) ? ZERO_LAT : FULL_LAT);
                accept_edge = edge_cnt + 1;
                in_flight   = 1'b1;
                n_sent++;
            end
        end
    end

    // result sink with random stall stretches when enabled
    initial begin
        int stall_left;
        stall_left = 0;
        o_ready = 1'b1;
        forever begin
            @(posedge aclk);
            #1;
            if (stall_left > 0) begin
                o_ready = 1'b0;
                stall_left--;
            end else if (stall_mode && ($urandom % 3 == 0)) begin
                o_ready = 1'b0;
                stall_left = int'($urandom % 12);
            end else begin
                o_ready = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin
        int      a;
        int      b;
        word_t   min_neg;
        div_op_t ops[4];
        seed_val   = $urandom(32'hd1821b49);
        ops        = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};
        min_neg    = word_t'(1) << (`DIV_XLEN - 1);
        aresetn    = 1'b0;
        i_valid    = 1'b0;
        i_op       = OP_DIVU;
        i_dividend = '0;
        i_divisor  = '0;
        repeat (16) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        @(posedge aclk);
        #1;
        // zero flag starts low after reset
        check_bit("o_div_zero", o_div_zero, 1'b0);
        // unsigned ops with the divisor shifted down for wide quotients
        for (int k = 0; k < 40; k++) begin
            send_op((k % 2 == 0) ? OP_DIVU : OP_REMU, rand_word(),
                    rand_word() >> ($urandom % `DIV_XLEN));
        end
        // small signed operands in all four sign pairs
        for (int k = 0; k < 32; k++) begin
            a = int'($urandom % 20);
            b = int'($urandom % 7) + 1;
            if (k[0]) begin
                a = -a;
            end
            if (k[1]) begin
                b = -b;
            end
            send_op(k[2] ? OP_REM : OP_DIV, word_t'(a), word_t'(b));
        end
        for (int k = 0; k < 20; k++) begin
            send_op(k[0] ? OP_REM : OP_DIV, rand_word(), rand_word() >> ($urandom % 8));
        end
        // zero divisor takes the short path
        for (int k = 0; k < 8; k++) begin
            send_op(ops[k % 4], rand_word(), '0);
        end
        // signed overflow
        send_op(OP_DIV, min_neg, '1);
        send_op(OP_REM, min_neg, '1);
        // back-pressure with back-to-back requests
        stall_mode = 1'b1;
        for (int k = 0; k < 60; k++) begin
            send_op(rand_op(), rand_word(), rand_word() >> ($urandom % `DIV_XLEN));
        end
        wait_drained(WAIT_LIMIT);
        repeat (2) @(posedge aclk);
        if (n_sent > 0 && n_done == n_sent && exp_result_q.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule

// File: tb.f
+incdir+common
+incdir+testbench
common/div_types_pkg.sv
common/div_ctrl_pkg.sv
divider/div_fsm.sv
divider/div_step_counter.sv
divider/div_operand_prep.sv
divider/div_restoring_core.sv
divider/div_result_fixup.sv
hdl/div_unit_top.sv
testbench/tb_div_unit.sv

// File: run_sim.sh
#!/bin/sh
# build the divide unit testbench with Verilator and run it
# the exit status is the simulation's own
set -e
cd "$(dirname "$0")"

verilator --binary --assert \
    --top-module tb_div_unit \
    -f tb.f \
    -Mdir obj_dir \
    -o tb_div_unit

./obj_dir/tb_div_unit
